// ==== common/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

	// frame geometry
	localparam int DATA_WIDTH   = 8;  // data bits per frame
	localparam int CLKS_PER_BIT = 8;  // tx_clk cycles per serial bit
	localparam int HALF_BIT     = CLKS_PER_BIT / 2; // start edge to middle of start bit
	localparam int SYNC_STAGES  = 3;  // flops on the asynchronous receive line

	// start + data + even parity + stop
	localparam int FRAME_BITS   = DATA_WIDTH + 3;

	// one data byte
	typedef logic [DATA_WIDTH-1:0] data_t;

	// counts tx_clk cycles inside one bit, 0 .. CLKS_PER_BIT-1
	typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_count_t;

	// counts bits inside one frame, 0 .. FRAME_BITS-1
	typedef logic [$clog2(FRAME_BITS)-1:0] bit_index_t;

	// transmitter FSM
	typedef enum logic {
		TX_IDLE  = 1'b0, // line high, ready for a byte
		TX_SHIFT = 1'b1  // frame on the line
	} tx_state_e;

	// receiver FSM, one state per frame field
	typedef enum logic [2:0] {
		RX_IDLE   = 3'd0, // waiting for the sampler to find a start edge
		RX_START  = 3'd1, // waiting for the start bit sample
		RX_DATA   = 3'd2, // shifting in data bits
		RX_PARITY = 3'd3, // waiting for the parity sample
		RX_STOP   = 3'd4  // waiting for the stop sample
	} rx_state_e;

endpackage

`default_nettype wire

// ==== common/rx_sample_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// link between the receive sampler and the deframer
interface rx_sample_if;

	logic sample_strobe; // one cycle at the middle of each bit
	logic sample_bit;    // synchronized line level, valid with the strobe
	logic frame_active;  // sampler is inside a frame
	logic frame_done;    // deframer is finished, sampler goes back to hunting

	modport sampler (
		output sample_strobe,
		output sample_bit,
		output frame_active,
		input  frame_done
	);

	modport deframer (
		input  sample_strobe,
		input  sample_bit,
		input  frame_active,
		output frame_done
	);

endinterface

`default_nettype wire

// ==== uart_tx/tx_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_serializer (
	input  logic            tx_clk,
	input  logic            reset_tx,
	input  logic            i_valid,  // byte offered by the source
	input  uart_pkg::data_t i_data,   // held by the source until taken
	output logic            o_ready,  // high only while idle
	output logic            o_serial  // serial line, high when idle
);

	uart_pkg::tx_state_e   state_q;
	uart_pkg::baud_count_t baud_cnt_q;  // cycle within the current bit
	uart_pkg::bit_index_t  bit_idx_q;   // frame bit now on the line

	// start bit goes straight to the line, so the register holds the rest
	// of the frame with bit 0 as the next bit to send
	logic [uart_pkg::FRAME_BITS-2:0] frame_q;

	logic take_byte;  // handshake completes on this edge
	logic bit_end;    // last cycle of the current bit
	logic last_bit;   // stop bit is on the line

	assign take_byte = i_valid & o_ready;
	assign bit_end   = (baud_cnt_q == uart_pkg::baud_count_t'(uart_pkg::CLKS_PER_BIT - 1));
	assign last_bit  = (bit_idx_q == uart_pkg::bit_index_t'(uart_pkg::FRAME_BITS - 1));

	// control: state, counters, ready and the line itself
	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state_q    <= uart_pkg::TX_IDLE;
			baud_cnt_q <= '0;
			bit_idx_q  <= '0;
			o_ready    <= 1'b1;  // ready straight out of reset
			o_serial   <= 1'b1;  // line idles high
		end else begin
			case (state_q)
				uart_pkg::TX_IDLE: begin
					if (take_byte) begin
						state_q    <= uart_pkg::TX_SHIFT;
						baud_cnt_q <= '0;
						bit_idx_q  <= '0;
						o_ready    <= 1'b0;  // busy for the whole frame
						o_serial   <= 1'b0;  // start bit on the next cycle
					end
				end

				uart_pkg::TX_SHIFT: begin
					if (bit_end) begin
						baud_cnt_q <= '0;
						if (last_bit) begin
							// stop bit has had its full time
							state_q  <= uart_pkg::TX_IDLE;
							o_ready  <= 1'b1;  // next byte may be taken here
							o_serial <= 1'b1;
						end else begin
							bit_idx_q <= bit_idx_q + 1'b1;
							o_serial  <= frame_q[0];  // lsb first
						end
					end else begin
						baud_cnt_q <= baud_cnt_q + 1'b1;
					end
				end

				default: begin
					state_q  <= uart_pkg::TX_IDLE;
					o_ready  <= 1'b1;
					o_serial <= 1'b1;
				end
			endcase
		end
	end

	// frame payload, loaded at the transfer and shifted once per bit
	always_ff @(posedge tx_clk) begin
		if (take_byte) begin
			frame_q <= {1'b1, ^i_data, i_data};  // stop, even parity, data
		end else if ((state_q == uart_pkg::TX_SHIFT) && bit_end) begin
			frame_q <= {1'b1, frame_q[uart_pkg::FRAME_BITS-2:1]};  // fill with idle level
		end
	end

endmodule

`default_nettype wire

// ==== uart_rx/rx_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_sampler (
	input  logic          tx_clk,
	input  logic          reset_tx,
	input  logic          i_serial,  // asynchronous receive line
	rx_sample_if.sampler  smp
);

	logic [uart_pkg::SYNC_STAGES-1:0] sync_q;  // synchronizer chain, bit 0 first
	logic                             line_now;   // synchronized line
	logic                             line_prev;  // line one cycle earlier
	logic                             start_edge; // falling edge while hunting

	uart_pkg::baud_count_t baud_cnt_q;  // cycles left to the next sample point
	logic                  active_q;    // inside a frame

	assign line_now   = sync_q[uart_pkg::SYNC_STAGES-1];
	assign start_edge = line_prev & ~line_now;

	// line flops, set to the idle level so reset gives no false edge
	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			sync_q    <= '1;
			line_prev <= 1'b1;
		end else begin
			sync_q    <= {sync_q[uart_pkg::SYNC_STAGES-2:0], i_serial};
			line_prev <= line_now;
		end
	end

	// hunt for a start edge, then count out the mid-bit sample points
	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			active_q   <= 1'b0;
			baud_cnt_q <= '0;
		end else if (!active_q) begin
			if (start_edge) begin
				active_q   <= 1'b1;
				baud_cnt_q <= uart_pkg::baud_count_t'(uart_pkg::HALF_BIT - 1); // to mid start bit
			end
		end else if (smp.frame_done) begin
			// deframer is through with this frame or dropped a glitch
			active_q   <= 1'b0;
			baud_cnt_q <= '0;
		end else if (baud_cnt_q == '0) begin
			baud_cnt_q <= uart_pkg::baud_count_t'(uart_pkg::CLKS_PER_BIT - 1); // one bit on
		end else begin
			baud_cnt_q <= baud_cnt_q - 1'b1;
		end
	end

	// strobe lands HALF_BIT cycles after the edge, then every CLKS_PER_BIT
	assign smp.sample_strobe = active_q & (baud_cnt_q == '0);
	assign smp.sample_bit    = line_now;
	assign smp.frame_active  = active_q;

endmodule

`default_nettype wire

// ==== uart_rx/rx_deframer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_deframer (
	input  logic            tx_clk,
	input  logic            reset_tx,
	rx_sample_if.deframer   smp,
	output logic            o_valid,  // one cycle per received frame
	output uart_pkg::data_t o_data,   // held until the next pulse
	output logic            o_error   // parity or stop bit wrong
);

	uart_pkg::rx_state_e  state_q;
	uart_pkg::bit_index_t bit_cnt_q;     // data bits taken so far
	uart_pkg::data_t      shift_q;       // data shift register, lsb arrives first
	logic                 parity_acc_q;  // running xor of the data bits
	logic                 parity_err_q;  // parity sample disagreed
	logic                 done_q;        // frame_done pulse
	logic                 last_data;     // strobe takes the final data bit

	assign last_data      = (bit_cnt_q == uart_pkg::bit_index_t'(uart_pkg::DATA_WIDTH - 1));
	assign smp.frame_done = done_q;

	// FSM and result flags
	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state_q      <= uart_pkg::RX_IDLE;
			bit_cnt_q    <= '0;
			parity_err_q <= 1'b0;
			done_q       <= 1'b0;
			o_valid      <= 1'b0;
			o_error      <= 1'b0;
		end else begin
			done_q  <= 1'b0;  // both are single cycle pulses
			o_valid <= 1'b0;
			case (state_q)
				uart_pkg::RX_IDLE: begin
					// frame_active lingers one cycle past frame_done
					if (smp.frame_active && !done_q) begin
						state_q <= uart_pkg::RX_START;
					end
				end

				uart_pkg::RX_START: begin
					if (smp.sample_strobe) begin
						if (smp.sample_bit) begin
							state_q <= uart_pkg::RX_IDLE;  // glitch, line back high
							done_q  <= 1'b1;
						end else begin
							state_q   <= uart_pkg::RX_DATA;
							bit_cnt_q <= '0;
						end
					end
				end

				uart_pkg::RX_DATA: begin
					if (smp.sample_strobe) begin
						bit_cnt_q <= bit_cnt_q + 1'b1;
						if (last_data) begin
							state_q <= uart_pkg::RX_PARITY;
						end
					end
				end

				uart_pkg::RX_PARITY: begin
					if (smp.sample_strobe) begin
						state_q      <= uart_pkg::RX_STOP;
						parity_err_q <= parity_acc_q ^ smp.sample_bit; // even parity
					end
				end

				uart_pkg::RX_STOP: begin
					if (smp.sample_strobe) begin
						state_q <= uart_pkg::RX_IDLE;
						o_valid <= 1'b1;
						o_error <= parity_err_q | ~smp.sample_bit; // low stop is a framing error
						done_q  <= 1'b1;
					end
				end

				default: state_q <= uart_pkg::RX_IDLE;
			endcase
		end
	end

	// payload side, only moves on a strobe
	always_ff @(posedge tx_clk) begin
		if (smp.sample_strobe) begin
			case (state_q)
				uart_pkg::RX_START: parity_acc_q <= 1'b0;
				uart_pkg::RX_DATA: begin
					shift_q      <= {smp.sample_bit, shift_q[uart_pkg::DATA_WIDTH-1:1]};
					parity_acc_q <= parity_acc_q ^ smp.sample_bit;
				end
				uart_pkg::RX_STOP: o_data <= shift_q;  // lands with o_valid
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/uart_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_core (
	input  logic            tx_clk,
	input  logic            reset_tx,

	// transmit byte handshake
	input  logic            i_tx_valid,
	input  uart_pkg::data_t i_tx_data,
	output logic            o_tx_ready,

	// serial lines, joined outside for loopback
	output logic            o_serial_tx,
	input  logic            i_serial_rx,

	// received byte
	output logic            o_rx_valid,
	output uart_pkg::data_t o_rx_data,
	output logic            o_rx_error
);

	rx_sample_if u_rx_link ();  // sampler to deframer

	// transmit path
	tx_serializer u_tx_serializer (
		.tx_clk   (tx_clk),
		.reset_tx (reset_tx),
		.i_valid  (i_tx_valid),
		.i_data   (i_tx_data),
		.o_ready  (o_tx_ready),
		.o_serial (o_serial_tx)
	);

	// receive path, sync and bit timing
	rx_sampler u_rx_sampler (
		.tx_clk   (tx_clk),
		.reset_tx (reset_tx),
		.i_serial (i_serial_rx),
		.smp      (u_rx_link.sampler)
	);

	// receive path, frame checks and result
	rx_deframer u_rx_deframer (
		.tx_clk   (tx_clk),
		.reset_tx (reset_tx),
		.smp      (u_rx_link.deframer),
		.o_valid  (o_rx_valid),
		.o_data   (o_rx_data),
		.o_error  (o_rx_error)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic o_clk  // tx_clk for the whole bench
);

	initial begin
		o_clk = 1'b0;
	end

	always #20 o_clk = ~o_clk;  // 40 ns period

endmodule

`default_nettype wire

// ==== testbench/tb_uart_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart_core;

	localparam int READY_TIMEOUT = 200;  // cycles, more than one frame
	localparam int RX_TIMEOUT    = 300;  // cycles from call to o_rx_valid
	localparam int FRAME_CYCLES  = uart_pkg::FRAME_BITS * uart_pkg::CLKS_PER_BIT;

	logic            tx_clk;
	logic            reset_tx;
	logic            tx_valid;
	uart_pkg::data_t tx_data;
	logic            tx_ready;
	logic            serial_tx;
	logic            serial_rx;
	logic            rx_valid;
	uart_pkg::data_t rx_data;
	logic            rx_error;

	logic            inject;       // high when the bench drives the receive line
	logic            inj_line;     // bench driven serial level
	integer          seed;
	uart_pkg::data_t stream_q[$];  // bytes queued for send_stream

	assign serial_rx = inject ? inj_line : serial_tx;  // loopback otherwise

	tb_clock_gen u_clock_gen (
		.o_clk (tx_clk)
	);

	uart_core u_uart_core (
		.tx_clk      (tx_clk),
		.reset_tx    (reset_tx),
		.i_tx_valid  (tx_valid),
		.i_tx_data   (tx_data),
		.o_tx_ready  (tx_ready),
		.o_serial_tx (serial_tx),
		.i_serial_rx (serial_rx),
		.o_rx_valid  (rx_valid),
		.o_rx_data   (rx_data),
		.o_rx_error  (rx_error)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_data(input string name, input uart_pkg::data_t got,
		input uart_pkg::data_t exp);
		if (got !== exp) begin
			abort_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	// expected line bits, start first
	function automatic logic [uart_pkg::FRAME_BITS-1:0] frame_of(input uart_pkg::data_t b,
		input logic par_flip, input logic stop_bit);
		return {stop_bit, (^b) ^ par_flip, b, 1'b0};  // even parity over the data
	endfunction

	// outputs are looked at on the falling edge, half a cycle after they move
	task automatic wait_tx_ready();
		int waited;
		waited = 0;
		@(negedge tx_clk);
		while (!tx_ready) begin
			waited++;
			if (waited > READY_TIMEOUT) begin
				abort_run("timeout, transmitter never became ready");
			end
			@(negedge tx_clk);
		end
	endtask

	task automatic expect_rx(input uart_pkg::data_t exp_data, input logic exp_err);
		int waited;
		waited = 0;
		@(negedge tx_clk);
		while (!rx_valid) begin
			waited++;
			if (waited > RX_TIMEOUT) begin
				abort_run("timeout, no byte came out of the receiver");
			end
			@(negedge tx_clk);
		end
		check_data("o_rx_data", rx_data, exp_data);
		check_flag("o_rx_error", rx_error, exp_err);
	endtask

	// valid stays high across the whole queue, source stalls on ready
	task automatic send_stream(input int count);
		int i;
		@(posedge tx_clk);
		tx_valid <= 1'b1;
		tx_data  <= stream_q[0];
		for (i = 0; i < count; i++) begin
			wait_tx_ready();
			@(posedge tx_clk);  // transfer edge
			if (i + 1 < count) begin
				tx_data <= stream_q[i+1];
			end else begin
				tx_valid <= 1'b0;
			end
		end
	endtask

	task automatic drive_frame(input logic [uart_pkg::FRAME_BITS-1:0] bits);
		int i;
		int c;
		for (i = 0; i < uart_pkg::FRAME_BITS; i++) begin
			for (c = 0; c < uart_pkg::CLKS_PER_BIT; c++) begin
				@(posedge tx_clk);
				inj_line <= bits[i];
			end
		end
		@(posedge tx_clk);
		inj_line <= 1'b1;  // back to idle
	endtask

	task automatic idle_after_reset();
		int i;
		for (i = 0; i < 20; i++) begin
			@(negedge tx_clk);
			check_flag("o_tx_ready", tx_ready, 1'b1);
			check_flag("o_serial_tx", serial_tx, 1'b1);
			check_flag("o_rx_valid", rx_valid, 1'b0);
		end
	endtask

	task automatic frame_shape_on_line();
		uart_pkg::data_t                 b;
		logic [uart_pkg::FRAME_BITS-1:0] exp;
		int                              i;
		int                              c;
		b   = 8'hA7;  // odd number of ones, parity bit is 1
		exp = frame_of(b, 1'b0, 1'b1);
		@(posedge tx_clk);
		tx_valid <= 1'b1;
		tx_data  <= b;
		wait_tx_ready();
		@(posedge tx_clk);  // transfer edge
		tx_valid <= 1'b0;
		fork
			begin
				for (i = 0; i < uart_pkg::FRAME_BITS; i++) begin
					for (c = 0; c < uart_pkg::CLKS_PER_BIT; c++) begin
						@(negedge tx_clk);
						check_flag("o_tx_ready", tx_ready, 1'b0);
						if (c == uart_pkg::HALF_BIT) begin
							check_flag("o_serial_tx", serial_tx, exp[i]);  // mid bit
						end
					end
				end
				@(negedge tx_clk);
				check_flag("o_tx_ready", tx_ready, 1'b1);  // free right after stop
			end
			expect_rx(b, 1'b0);  // same frame comes back through loopback
		join
	endtask

	task automatic loopback_one_byte();
		uart_pkg::data_t b;
		b = uart_pkg::data_t'($random(seed));
		stream_q.delete();
		stream_q.push_back(b);
		fork
			send_stream(1);
			expect_rx(b, 1'b0);
		join
	endtask

	task automatic loopback_burst();
		int i;
		stream_q.delete();
		for (i = 0; i < 8; i++) begin
			stream_q.push_back(uart_pkg::data_t'($random(seed)));
		end
		fork
			send_stream(8);
			begin
				for (i = 0; i < 8; i++) begin
					expect_rx(stream_q[i], 1'b0);  // in order, no error
				end
			end
		join
	endtask

	task automatic injected_bad_frames();
		uart_pkg::data_t b;
		int              i;
		@(posedge tx_clk);
		inject <= 1'b1;  // both sources idle high, no edge on the switch
		b = uart_pkg::data_t'($random(seed));
		fork
			drive_frame(frame_of(b, 1'b1, 1'b1));  // parity inverted
			expect_rx(b, 1'b1);
		join
		repeat (8) @(posedge tx_clk);
		b = uart_pkg::data_t'($random(seed));
		fork
			drive_frame(frame_of(b, 1'b0, 1'b0));  // stop bit low
			expect_rx(b, 1'b1);
		join
		repeat (8) @(posedge tx_clk);
		@(posedge tx_clk);
		inj_line <= 1'b0;  // short low pulse, gone before mid start bit
		repeat (2) @(posedge tx_clk);
		inj_line <= 1'b1;
		for (i = 0; i < FRAME_CYCLES; i++) begin
			@(negedge tx_clk);
			check_flag("o_rx_valid", rx_valid, 1'b0);
		end
		b = uart_pkg::data_t'($random(seed));
		fork
			drive_frame(frame_of(b, 1'b0, 1'b1));  // clean frame after the glitch
			expect_rx(b, 1'b0);
		join
		@(posedge tx_clk);
		inject <= 1'b0;
	endtask

	initial begin
		reset_tx = 1'b1;
		tx_valid = 1'b0;
		tx_data  = '0;
		inject   = 1'b0;
		inj_line = 1'b1;
		seed     = 44;
		repeat (8) @(posedge tx_clk);
		reset_tx <= 1'b0;

		idle_after_reset();
		frame_shape_on_line();
		loopback_one_byte();
		loopback_burst();
		injected_bad_frames();

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
common/uart_pkg.sv
common/rx_sample_if.sv
uart_tx/tx_serializer.sv
uart_rx/rx_sampler.sv
uart_rx/rx_deframer.sv
verilog/uart_core.sv
testbench/tb_clock_gen.sv
testbench/tb_uart_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then decide from the simulation log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_uart_core -f compile.f -o sim_uart \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_uart > sim.log 2>&1
cat sim.log

grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0
